/* logic/decode_cfg.svh */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Datapath and instruction word width
`define DEC_XLEN        32

// Architectural registers, also the one-hot lock vector width
`define DEC_REG_COUNT   32

// Register address width, log2 of DEC_REG_COUNT
`define DEC_REG_ADDR_W  5

// Instruction tag carried through to execute
`define DEC_TAG_W       4

// Cycles a pending write stays in the lock queue
`define DEC_LOCK_DEPTH  2

`endif

/* logic/decode_pkg.sv */
`include "decode_cfg.svh"

package decode_pkg;

    // Execute unit that receives the instruction
    typedef enum logic [2:0] {
        bypass  = 3'd0,                         // No unit, pass-through
        adder   = 3'd1,
        logical = 3'd2,
        shifter = 3'd3,
        branch  = 3'd4,                         // Branches and jumps
        memory  = 3'd5                          // Loads and stores
    } exec_unit_e;

    // Operation selector inside the unit
    typedef enum logic [2:0] {
        op0 = 3'd0,
        op1 = 3'd1,
        op2 = 3'd2,
        op3 = 3'd3,
        op4 = 3'd4,
        op5 = 3'd5,
        op6 = 3'd6,
        op7 = 3'd7
    } instr_op_e;

    // RV32I encoding formats
    typedef enum logic [2:0] {
        fmt_r = 3'd0,
        fmt_i = 3'd1,
        fmt_s = 3'd2,
        fmt_b = 3'd3,
        fmt_u = 3'd4,
        fmt_j = 3'd5
    } instr_fmt_e;

    // Register view of the instruction word
    typedef struct packed {
        logic [6:0]                   funct7;
        logic [`DEC_REG_ADDR_W-1:0]   rs2;
        logic [`DEC_REG_ADDR_W-1:0]   rs1;
        logic [2:0]                   funct3;
        logic [`DEC_REG_ADDR_W-1:0]   rd;
        logic [6:0]                   opcode;
    } instr_r_t;

    // Immediate view, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0]                  imm12;
        logic [`DEC_REG_ADDR_W-1:0]   rs1;
        logic [2:0]                   funct3;
        logic [`DEC_REG_ADDR_W-1:0]   rd;
        logic [6:0]                   opcode;
    } instr_i_t;

    // One 32-bit word, two decodings
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_word_u;

endpackage

/* logic/instr_classifier.sv */
`timescale 1ns/10ps

module instr_classifier (
    input  decode_pkg::instr_word_u instr,      // Current instruction word
    output decode_pkg::exec_unit_e  unit,       // Target execute unit
    output decode_pkg::instr_op_e   op,         // Operation inside the unit
    output decode_pkg::instr_fmt_e  fmt         // Encoding format
);
    import decode_pkg::*;

    // Internal mnemonic, only the kept RV32I subset
    typedef enum logic [4:0] {
        mn_lui, mn_add, mn_sub, mn_slt, mn_sltu,
        mn_xor, mn_or, mn_and, mn_sll, mn_srl, mn_sra,
        mn_jal, mn_jalr, mn_beq, mn_bne, mn_blt, mn_bge, mn_bltu, mn_bgeu,
        mn_lb, mn_lh, mn_lw, mn_lbu, mn_lhu, mn_sb, mn_sh, mn_sw,
        mn_invalid
    } mnemonic_e;

    mnemonic_e mn;

    always_comb begin
        mn = mn_invalid;                        // Unknown words fall through here
        case (instr.r.opcode)
            7'b0110111: mn = mn_lui;
            7'b0010111: mn = mn_add;            // AUIPC reuses the adder
            7'b1101111: mn = mn_jal;
            7'b1100111: if (instr.r.funct3 == 3'b000) mn = mn_jalr;
            7'b1100011: case (instr.r.funct3)   // Branches
                3'b000: mn = mn_beq;
                3'b001: mn = mn_bne;
                3'b100: mn = mn_blt;
                3'b101: mn = mn_bge;
                3'b110: mn = mn_bltu;
                3'b111: mn = mn_bgeu;
                default: mn = mn_invalid;
            endcase
            7'b0000011: case (instr.r.funct3)   // Loads
                3'b000: mn = mn_lb;
                3'b001: mn = mn_lh;
                3'b010: mn = mn_lw;
                3'b100: mn = mn_lbu;
                3'b101: mn = mn_lhu;
                default: mn = mn_invalid;
            endcase
            7'b0100011: case (instr.r.funct3)   // Stores
                3'b000: mn = mn_sb;
                3'b001: mn = mn_sh;
                3'b010: mn = mn_sw;
                default: mn = mn_invalid;
            endcase
            7'b0010011: case (instr.r.funct3)   // ALU with immediate
                3'b000: mn = mn_add;            // ADDI
                3'b010: mn = mn_slt;
                3'b011: mn = mn_sltu;
                3'b100: mn = mn_xor;
                3'b110: mn = mn_or;
                3'b111: mn = mn_and;
                3'b001: if (instr.r.funct7 == 7'b0000000) mn = mn_sll;
                3'b101: if (instr.r.funct7 == 7'b0000000) mn = mn_srl;
                        else if (instr.r.funct7 == 7'b0100000) mn = mn_sra;
                default: mn = mn_invalid;
            endcase
            7'b0110011: case ({instr.r.funct7, instr.r.funct3}) // Register ALU
                {7'b0000000, 3'b000}: mn = mn_add;
                {7'b0100000, 3'b000}: mn = mn_sub;
                {7'b0000000, 3'b001}: mn = mn_sll;
                {7'b0000000, 3'b010}: mn = mn_slt;
                {7'b0000000, 3'b011}: mn = mn_sltu;
                {7'b0000000, 3'b100}: mn = mn_xor;
                {7'b0000000, 3'b101}: mn = mn_srl;
                {7'b0100000, 3'b101}: mn = mn_sra;
                {7'b0000000, 3'b110}: mn = mn_or;
                {7'b0000000, 3'b111}: mn = mn_and;
                default: mn = mn_invalid;
            endcase
            default: mn = mn_invalid;           // CSR, FENCE, ECALL land here
        endcase
    end

    always_comb begin
        case (mn)                               // Unit table
            mn_add, mn_sub, mn_slt, mn_sltu:                     unit = adder;
            mn_xor, mn_or, mn_and:                               unit = logical;
            mn_sll, mn_srl, mn_sra:                              unit = shifter;
            mn_beq, mn_bne, mn_blt, mn_bge, mn_bltu, mn_bgeu,
            mn_jal, mn_jalr:                                     unit = branch;
            mn_lb, mn_lh, mn_lw, mn_lbu, mn_lhu,
            mn_sb, mn_sh, mn_sw:                                 unit = memory;
            default:                                             unit = bypass; // LUI too
        endcase
    end

    always_comb begin
        case (mn)                               // Op code table
            mn_add, mn_xor, mn_sll, mn_beq, mn_lb:          op = op0;
            mn_sub, mn_or, mn_srl, mn_bne, mn_lbu, mn_lui:  op = op1;
            mn_sltu, mn_and, mn_sra, mn_blt, mn_lh:         op = op2;
            mn_slt, mn_bltu, mn_lhu:                        op = op3;
            mn_bge, mn_lw:                                  op = op4;
            mn_bgeu, mn_sw:                                 op = op5;
            mn_jal, mn_sh:                                  op = op6;
            mn_jalr, mn_sb:                                 op = op7;
            default:                                        op = op0;
        endcase
    end

    always_comb begin
        case (instr.r.opcode)                   // Format by opcode only
            7'b0010011, 7'b1100111, 7'b0000011: fmt = fmt_i;
            7'b0100011:                         fmt = fmt_s;
            7'b1100011:                         fmt = fmt_b;
            7'b0110111, 7'b0010111:             fmt = fmt_u;
            7'b1101111:                         fmt = fmt_j;
            default:                            fmt = fmt_r;
        endcase
    end

endmodule

/* logic/imm_generator.sv */
`timescale 1ns/10ps

`include "decode_cfg.svh"

module imm_generator (
    input  decode_pkg::instr_word_u  instr,     // Instruction word
    input  decode_pkg::instr_fmt_e   fmt,       // Format from the classifier
    output logic [`DEC_XLEN-1:0]     imm        // Sign-extended immediate
);
    import decode_pkg::*;

    always_comb begin
        case (fmt)
            fmt_i: begin                        // imm[11:0] straight from the I view
                imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
            end
            fmt_s: begin                        // Split field, funct7 and rd slots
                imm = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
            end
            fmt_b: begin                        // Halfword offset
                imm = {{20{instr.r.funct7[6]}},
                       instr.r.rd[0],           // imm[11]
                       instr.r.funct7[5:0],     // imm[10:5]
                       instr.r.rd[4:1],         // imm[4:1]
                       1'b0};
            end
            fmt_u: begin                        // Upper 20 bits, low part zero
                imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3,
                       12'b0};
            end
            fmt_j: begin                        // JAL offset, +/-1 MiB
                imm = {{12{instr.r.funct7[6]}},
                       instr.r.rs1,             // imm[19:15]
                       instr.r.funct3,          // imm[14:12]
                       instr.r.rs2[0],          // imm[11]
                       instr.r.funct7[5:0],     // imm[10:5]
                       instr.r.rs2[4:1],        // imm[4:1]
                       1'b0};
            end
            default: begin
                imm = '0;                       // R format has no immediate
            end
        endcase
    end

endmodule

/* logic/reg_lock_queue.sv */
`timescale 1ns/10ps

`include "decode_cfg.svh"

module reg_lock_queue #(
    parameter int DEPTH = `DEC_LOCK_DEPTH       // Cycles a write stays locked
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           we,      // Global write enable
    input  decode_pkg::instr_word_u        instr,
    input  decode_pkg::exec_unit_e         unit,
    input  decode_pkg::instr_op_e          op,
    input  decode_pkg::instr_fmt_e         fmt,
    output logic                           bubble,  // Hazard, active high
    output logic [`DEC_REG_COUNT-1:1]      wr_addr  // One-hot write address
);
    import decode_pkg::*;

    logic [`DEC_REG_COUNT-1:0] queue [DEPTH];   // Entry 0 is the newest
    logic [`DEC_REG_COUNT-1:0] locked;          // OR of all pending writes
    logic [`DEC_REG_COUNT-1:0] target;          // Lock bits of current instruction
    logic                      writes_rd;
    logic                      is_store;
    logic                      is_load;
    logic                      reads_rs1;
    logic                      reads_rs2;

    assign writes_rd = (fmt inside {fmt_r, fmt_i, fmt_u, fmt_j}) && (instr.r.rd != '0);
    assign is_store  = (unit == memory) && (op inside {op5, op6, op7});
    assign is_load   = (unit == memory) && (op inside {op0, op1, op2, op3, op4});
    assign reads_rs1 = fmt inside {fmt_r, fmt_i, fmt_s, fmt_b};
    assign reads_rs2 = fmt inside {fmt_r, fmt_s, fmt_b};

    always_comb begin
        target = '0;
        if (writes_rd)
            target[instr.r.rd] = 1'b1;          // rd is nonzero, bit 0 stays free
        else if (is_store)
            target[0] = 1'b1;                   // Bit 0 marks a pending memory write
    end

    always_comb begin
        locked = '0;
        for (int w = 0; w < DEPTH; w++)
            locked = locked | queue[w];
    end

    // RAW on a register, or a load behind a pending store
    assign bubble = (reads_rs1 && locked[instr.r.rs1]) ||
                    (reads_rs2 && locked[instr.r.rs2]) ||
                    (is_load && locked[0]);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int j = 0; j < DEPTH; j++)
                queue[j] <= '0;
        end else begin
            for (int k = DEPTH - 1; k > 0; k--)
                queue[k] <= queue[k-1];         // Age every entry by one
            queue[0] <= bubble ? '0 : target;   // A stalled word locks nothing
        end
    end

    assign wr_addr = queue[DEPTH-1][`DEC_REG_COUNT-1:1] & {(`DEC_REG_COUNT-1){we}};

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/10ps

`include "decode_cfg.svh"

module decode_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            we,        // Global write enable
    input  logic                            flush,     // Forces a bubble, active high
    input  decode_pkg::instr_word_u         instr,     // Held by fetch during a bubble
    input  logic [`DEC_XLEN-1:0]            npc,       // Next PC from fetch
    input  logic [`DEC_TAG_W-1:0]           tag_in,
    input  logic [`DEC_XLEN-1:0]            data_a,    // Register bank port A
    input  logic [`DEC_XLEN-1:0]            data_b,    // Register bank port B
    output logic [`DEC_REG_ADDR_W-1:0]      rs1_addr,  // Same-cycle bank read
    output logic [`DEC_REG_ADDR_W-1:0]      rs2_addr,
    output logic [`DEC_REG_COUNT-1:1]       wr_addr,   // Delayed one-hot write enables
    output logic [`DEC_XLEN-1:0]            op_a,
    output logic [`DEC_XLEN-1:0]            op_b,
    output logic [`DEC_XLEN-1:0]            op_c,
    output logic [`DEC_XLEN-1:0]            npc_out,
    output decode_pkg::instr_op_e           op_sel,
    output decode_pkg::exec_unit_e          unit_sel,
    output logic [`DEC_TAG_W-1:0]           tag_out,
    output logic                            bubble     // Hazard, active high
);
    import decode_pkg::*;

    exec_unit_e            unit;
    instr_op_e             op;
    instr_fmt_e            fmt;
    logic [`DEC_XLEN-1:0]  imm;
    logic [`DEC_XLEN-1:0]  sel_a;
    logic [`DEC_XLEN-1:0]  sel_b;
    logic [`DEC_XLEN-1:0]  sel_c;

    instr_classifier u_classifier (
        .instr (instr),
        .unit  (unit),
        .op    (op),
        .fmt   (fmt)
    );

    imm_generator u_imm (
        .instr (instr),
        .fmt   (fmt),
        .imm   (imm)
    );

    reg_lock_queue u_lock (
        .clk     (clk),
        .reset   (reset),
        .we      (we),
        .instr   (instr),
        .unit    (unit),
        .op      (op),
        .fmt     (fmt),
        .bubble  (bubble),
        .wr_addr (wr_addr)
    );

    assign rs1_addr = instr.r.rs1;              // Bank answers in this cycle
    assign rs2_addr = instr.r.rs2;

    // Operand routing by format
    assign sel_a = (fmt == fmt_u || fmt == fmt_j) ? npc : data_a;   // PC-relative base
    assign sel_b = (fmt == fmt_r || fmt == fmt_b) ? data_b : imm;
    assign sel_c = (fmt == fmt_s) ? data_b : imm;                   // Store data

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            op_a     <= '0;
            op_b     <= '0;
            op_c     <= '0;
            npc_out  <= '0;
            op_sel   <= op0;
            unit_sel <= bypass;
            tag_out  <= '0;
        end else if (bubble || flush) begin     // Issue a NOP to execute
            op_a     <= '0;
            op_b     <= '0;
            op_c     <= '0;
            npc_out  <= '0;
            op_sel   <= op0;
            unit_sel <= bypass;
            tag_out  <= '0;
        end else begin
            op_a     <= sel_a;
            op_b     <= sel_b;
            op_c     <= sel_c;
            npc_out  <= npc;
            op_sel   <= op;
            unit_sel <= unit;
            tag_out  <= tag_in;
        end
    end

endmodule

/* dv/decode_stage_tb.sv */
`timescale 1ns/10ps

`include "decode_cfg.svh"

module decode_stage_tb;
    import decode_pkg::*;

    localparam int SRC_A = 1;                   // data_a
    localparam int SRC_B = 2;                   // data_b
    localparam int SRC_I = 3;                   // Immediate
    localparam int SRC_N = 4;                   // npc
    localparam int ROWS  = 18;

    logic                       clk;
    logic                       reset;
    logic                       we;
    logic                       flush;
    instr_word_u                instr;
    logic [`DEC_XLEN-1:0]       npc;
    logic [`DEC_TAG_W-1:0]      tag_in;
    logic [`DEC_XLEN-1:0]       data_a;
    logic [`DEC_XLEN-1:0]       data_b;
    logic [`DEC_REG_ADDR_W-1:0] rs1_addr;
    logic [`DEC_REG_ADDR_W-1:0] rs2_addr;
    logic [`DEC_REG_COUNT-1:1]  wr_addr;
    logic [`DEC_XLEN-1:0]       op_a;
    logic [`DEC_XLEN-1:0]       op_b;
    logic [`DEC_XLEN-1:0]       op_c;
    logic [`DEC_XLEN-1:0]       npc_out;
    instr_op_e                  op_sel;
    exec_unit_e                 unit_sel;
    logic [`DEC_TAG_W-1:0]      tag_out;
    logic                       bubble;

    // Stimulus and expected values per row
    logic [31:0] t_instr [ROWS];
    logic [31:0] t_npc   [ROWS];
    logic [3:0]  t_tag   [ROWS];
    logic        t_flush [ROWS];
    logic        t_we    [ROWS];
    logic [2:0]  t_unit  [ROWS];
    logic [2:0]  t_op    [ROWS];
    logic        t_bub   [ROWS];
    logic [30:0] t_wr    [ROWS];
    int          t_sa    [ROWS];
    int          t_sb    [ROWS];
    int          t_sc    [ROWS];

    logic [15:0] lfsr;
    int          errors;
    int          checks;

    decode_stage UUT (
        .clk(clk), .reset(reset), .we(we), .flush(flush), .instr(instr), .npc(npc),
        .tag_in(tag_in), .data_a(data_a), .data_b(data_b), .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr), .wr_addr(wr_addr), .op_a(op_a), .op_b(op_b), .op_c(op_c),
        .npc_out(npc_out), .op_sel(op_sel), .unit_sel(unit_sel), .tag_out(tag_out),
        .bubble(bubble)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 10 ns period
    end

    initial begin
        #20000;                                 // Watchdog for the whole run
        $display("Timeout, the run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    // Fibonacci LFSR x^16+x^14+x^13+x^11 stepped once per bit
    task automatic rand_word(output logic [31:0] w);
        logic fb;
        for (int n = 0; n < 32; n++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            w[n] = fb;
        end
    endtask

    // RV32I immediate straight from the encoding rules
    function automatic logic [31:0] expect_imm(input logic [31:0] w);
        case (w[6:0])
            7'b0010011, 7'b1100111, 7'b0000011: return {{20{w[31]}}, w[31:20]};
            7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
            7'b1100011: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
            7'b1101111: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] pick(input int src, input logic [31:0] w,
                                         input logic [31:0] a, input logic [31:0] b,
                                         input logic [31:0] pc);
        case (src)
            SRC_A: return a;
            SRC_B: return b;
            SRC_N: return pc;
            default: return expect_imm(w);
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic add_row(input int r, input logic [31:0] w, input logic [31:0] pc,
                           input logic [3:0] tg, input logic fl, input logic wen,
                           input logic [2:0] un, input logic [2:0] o, input logic bb,
                           input logic [30:0] wr, input int sa, input int sb,
                           input int sc);
        t_instr[r] = w;
        t_npc[r]   = pc;
        t_tag[r]   = tg;
        t_flush[r] = fl;
        t_we[r]    = wen;
        t_unit[r]  = un;
        t_op[r]    = o;
        t_bub[r]   = bb;
        t_wr[r]    = wr;
        t_sa[r]    = sa;
        t_sb[r]    = sb;
        t_sc[r]    = sc;
    endtask

    // Registered outputs of the previous row or the bubble values
    task automatic check_regs(input int r, input logic [31:0] a, input logic [31:0] b);
        logic nop;
        nop = (r < 0) ? 1'b1 : (t_bub[r] || t_flush[r]);
        if (nop) begin
            check_val("op_a", op_a, 32'h0);
            check_val("op_b", op_b, 32'h0);
            check_val("op_c", op_c, 32'h0);
            check_val("npc_out", npc_out, 32'h0);
            check_val("tag_out", {28'h0, tag_out}, 32'h0);
            check_val("op_sel", {29'h0, op_sel}, 32'h0);
            check_val("unit_sel", {29'h0, unit_sel}, 32'h0);
        end else begin
            check_val("op_a", op_a, pick(t_sa[r], t_instr[r], a, b, t_npc[r]));
            check_val("op_b", op_b, pick(t_sb[r], t_instr[r], a, b, t_npc[r]));
            check_val("op_c", op_c, pick(t_sc[r], t_instr[r], a, b, t_npc[r]));
            check_val("npc_out", npc_out, t_npc[r]);
            check_val("tag_out", {28'h0, tag_out}, {28'h0, t_tag[r]});
            check_val("op_sel", {29'h0, op_sel}, {29'h0, t_op[r]});
            check_val("unit_sel", {29'h0, unit_sel}, {29'h0, t_unit[r]});
        end
    endtask

    initial begin
        logic [31:0] prev_a;
        logic [31:0] prev_b;
        int          wait_cnt;
        // Unit codes are 0 bypass, 1 adder, 2 logical, 3 shifter, 4 branch, 5 memory
        add_row(0,  32'hFFB00093, 32'h100, 4'h1, 0, 1, 1, 0, 0, 31'h0, SRC_A, SRC_I, SRC_I);
        add_row(1,  32'h12345137, 32'h104, 4'h2, 0, 1, 0, 1, 0, 31'h0, SRC_N, SRC_I, SRC_I);
        add_row(2,  32'h005201B3, 32'h108, 4'h3, 0, 1, 1, 0, 0, 31'h1, SRC_A, SRC_B, SRC_I);
        add_row(3,  32'hFE332E23, 32'h10C, 4'h4, 0, 1, 5, 5, 1, 31'h2, SRC_A, SRC_I, SRC_B);
        add_row(4,  32'hFE332E23, 32'h10C, 4'h4, 0, 1, 5, 5, 1, 31'h4, SRC_A, SRC_I, SRC_B);
        add_row(5,  32'hFE332E23, 32'h10C, 4'h4, 0, 1, 5, 5, 0, 31'h0, SRC_A, SRC_I, SRC_B);
        add_row(6,  32'h00802383, 32'h110, 4'h5, 0, 1, 5, 4, 1, 31'h0, SRC_A, SRC_I, SRC_I);
        add_row(7,  32'h00802383, 32'h110, 4'h5, 0, 1, 5, 4, 1, 31'h0, SRC_A, SRC_I, SRC_I);
        add_row(8,  32'h00802383, 32'h110, 4'h5, 0, 1, 5, 4, 0, 31'h0, SRC_A, SRC_I, SRC_I);
        add_row(9,  32'hFE2088E3, 32'h114, 4'h6, 0, 1, 4, 0, 0, 31'h0, SRC_A, SRC_B, SRC_I);
        add_row(10, 32'h0010046F, 32'h118, 4'h7, 0, 0, 4, 6, 0, 31'h0, SRC_N, SRC_I, SRC_I);
        add_row(11, 32'h40345493, 32'h11C, 4'h8, 0, 1, 3, 2, 1, 31'h0, SRC_A, SRC_I, SRC_I);
        add_row(12, 32'h40345493, 32'h11C, 4'h8, 0, 1, 3, 2, 1, 31'h80, SRC_A, SRC_I, SRC_I);
        add_row(13, 32'h40345493, 32'h11C, 4'h8, 0, 1, 3, 2, 0, 31'h0, SRC_A, SRC_I, SRC_I);
        add_row(14, 32'h00000073, 32'h120, 4'h9, 0, 1, 0, 0, 0, 31'h0, SRC_A, SRC_B, SRC_I);
        add_row(15, 32'hFFFFF517, 32'h124, 4'hA, 0, 1, 1, 0, 0, 31'h100, SRC_N, SRC_I, SRC_I);
        add_row(16, 32'h0F02F613, 32'h128, 4'hB, 0, 1, 2, 2, 0, 31'h0, SRC_A, SRC_I, SRC_I);
        add_row(17, 32'h00000013, 32'h12C, 4'hC, 1, 1, 1, 0, 0, 31'h200, SRC_A, SRC_I, SRC_I);

        errors = 0;
        checks = 0;
        lfsr   = 16'd780;
        reset  = 1'b0;                          // Reset held from time zero
        we     = 1'b0;
        flush  = 1'b0;
        instr  = 32'h0;
        npc    = 32'h0;
        tag_in = 4'h0;
        data_a = 32'h0;
        data_b = 32'h0;
        prev_a = 32'h0;
        prev_b = 32'h0;

        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            check_regs(-1, 32'h0, 32'h0);       // Bubble values during reset
            check_val("bubble", {31'h0, bubble}, 32'h0);
        end
        reset = 1'b1;

        wait_cnt = 0;
        while (bubble !== 1'b0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 20) begin
                $display("bubble did not drop within 20 cycles of reset release");
                $display("SIMULATION FAILED");
                $finish;
            end
        end
        we = 1'b1;                              // Queue contents visible on wr_addr
        #1;
        check_val("wr_addr", {1'b0, wr_addr}, 32'h0);

        for (int r = 0; r < ROWS; r++) begin
            @(negedge clk);
            if (r > 0)
                check_regs(r - 1, prev_a, prev_b);
            instr  = t_instr[r];
            npc    = t_npc[r];
            tag_in = t_tag[r];
            flush  = t_flush[r];
            we     = t_we[r];
            rand_word(data_a);
            rand_word(data_b);
            prev_a = data_a;
            prev_b = data_b;
            #1;
            check_val("bubble", {31'h0, bubble}, {31'h0, t_bub[r]});
            check_val("wr_addr", {1'b0, wr_addr}, {1'b0, t_wr[r]});
            check_val("rs1_addr", {27'h0, rs1_addr}, {27'h0, t_instr[r][19:15]});
            check_val("rs2_addr", {27'h0, rs2_addr}, {27'h0, t_instr[r][24:20]});
        end
        @(negedge clk);
        check_regs(ROWS - 1, prev_a, prev_b);

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* decode_stage.f */
+incdir+logic
logic/decode_pkg.sv
logic/instr_classifier.sv
logic/imm_generator.sv
logic/reg_lock_queue.sv
logic/decode_stage.sv
dv/decode_stage_tb.sv
